//--- Makefile
VERILATOR ?= verilator
TOP       ?= proc_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
FAIL_MSG  ?= Verification failed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; exit 1; \
	else \
		echo "Simulation PASSED"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- all.f
src/proc_pkg.sv
src/stage_reg.sv
src/decode.sv
src/hazard_unit.sv
src/forwarding_unit.sv
src/alu.sv
src/data_mem.sv
src/proc.sv
verif/proc_tb.sv

//--- src/alu.sv
`timescale 1ns/10ps

module alu (
   input  proc_pkg::alu_op_t          op,
   input  logic [proc_pkg::XLEN-1:0]  a,
   input  logic [proc_pkg::XLEN-1:0]  b,
   output logic [proc_pkg::XLEN-1:0]  result
);

   import proc_pkg::*;

   logic [4:0] shamt;
   logic       lt;

   assign shamt = b[4:0];
   assign lt    = $signed(a) < $signed(b);

   ////////////////////
   // Function select
   always_comb begin
      case (op)
         // Also forms load and store addresses
         ALU_ADD: begin
            result = a + b;
         end
         ALU_SUB: begin
            result = a - b;
         end
         ALU_AND: begin
            result = a & b;
         end
         ALU_OR: begin
            result = a | b;
         end
         ALU_XOR: begin
            result = a ^ b;
         end
         ALU_SLT: begin
            result = {{(XLEN - 1){1'b0}}, lt};
         end
         // Logical shifts, zero fill
         ALU_SLL: begin
            result = a << shamt;
         end
         ALU_SRL: begin
            result = a >> shamt;
         end
         default: begin
            result = '0;
         end
      endcase
   end

endmodule

//--- src/data_mem.sv
`timescale 1ns/10ps

module data_mem #(
   parameter int DMEM_WORDS = 64
) (
   input  logic                      clk,
   input  logic                      read,
   input  logic                      write,
   input  logic                      byte_sel,
   input  logic [proc_pkg::XLEN-1:0] addr,
   input  logic [proc_pkg::XLEN-1:0] wdata,
   output logic [proc_pkg::XLEN-1:0] rdata
);

   import proc_pkg::*;

   localparam int AW = $clog2(DMEM_WORDS);

   logic [XLEN-1:0] mem [DMEM_WORDS];
   logic [5:0]      word_addr;
   logic [AW-1:0]   idx;
   logic [1:0]      lane;
   logic [XLEN-1:0] word;

   // Word from addr[7:2], wrapped to the array size
   assign word_addr = addr[7:2];
   assign idx       = AW'(int'(word_addr) % DMEM_WORDS);
   assign lane      = addr[1:0];
   assign word      = mem[idx];

   ////////////////////
   // Combinational read, byte loads zero-extended
   always_comb begin
      if (!read) begin
         rdata = '0;
      end else if (byte_sel) begin
         rdata = {{(XLEN - 8){1'b0}}, word[8 * lane +: 8]};
      end else begin
         rdata = word;
      end
   end

   // Write at the end of M, byte store touches one lane only
   always_ff @(posedge clk) begin
      if (write) begin
         if (byte_sel) begin
            mem[idx][8 * lane +: 8] <= wdata[7:0];
         end else begin
            mem[idx] <= wdata;
         end
      end
   end

endmodule

//--- src/decode.sv
`timescale 1ns/10ps

module decode (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic [proc_pkg::XLEN-1:0]       ir,
   input  logic                            wb_write,
   input  logic [proc_pkg::REG_IDX_W-1:0]  wb_index,
   input  logic [proc_pkg::XLEN-1:0]       wb_data,
   output proc_pkg::id_ex_t                id_out
);

   import proc_pkg::*;

   logic [XLEN-1:0]      regs [32];
   logic [OPC_W-1:0]     opcode;
   logic [REG_IDX_W-1:0] rd_idx;
   logic [REG_IDX_W-1:0] rs1_idx;
   logic [REG_IDX_W-1:0] rs2_idx;
   logic                 is_store;

   // Write-through read, r0 hardwired to zero
   function automatic logic [XLEN-1:0] read_reg(input logic [REG_IDX_W-1:0] idx);
      logic [XLEN-1:0] val;
      if (idx == '0) begin
         val = '0;
      end else if (wb_write && (wb_index == idx)) begin
         val = wb_data;
      end else begin
         val = regs[idx];
      end
      return val;
   endfunction

   ////////////////////
   // Register file, written in WB
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         regs <= '{default: '0};
      end else if (wb_write && (wb_index != '0)) begin
         regs[wb_index] <= wb_data;
      end
   end

   assign opcode   = ir[FLD_OPC_HI:FLD_OPC_LO];
   assign rd_idx   = ir[FLD_RD_HI:FLD_RD_LO];
   assign rs1_idx  = ir[FLD_RS1_HI:FLD_RS1_LO];
   assign is_store = (opcode == OP_STW) || (opcode == OP_STB);

   // Stores carry their data register in the rd field
   assign rs2_idx = is_store ? rd_idx : ir[FLD_RS2_HI:FLD_RS2_LO];

   ////////////////////
   // Opcode to control
   always_comb begin
      id_out          = '0;
      id_out.rs1      = rs1_idx;
      id_out.rs2      = rs2_idx;
      id_out.rd       = rd_idx;
      id_out.rs1_data = read_reg(rs1_idx);
      id_out.rs2_data = read_reg(rs2_idx);
      id_out.imm      = {{(XLEN - 16){ir[FLD_IMM_HI]}}, ir[FLD_IMM_HI:FLD_IMM_LO]};
      id_out.alu_op   = ALU_ADD;

      case (opcode)
         OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_SLL, OP_SRL: begin
            id_out.valid               = 1'b1;
            id_out.ctrl[CTL_REG_WRITE] = 1'b1;
            id_out.y_sel               = 1'b1;
            id_out.use_rs1             = 1'b1;
            id_out.use_rs2             = 1'b1;
            case (opcode)
               OP_SUB:  id_out.alu_op = ALU_SUB;
               OP_AND:  id_out.alu_op = ALU_AND;
               OP_OR:   id_out.alu_op = ALU_OR;
               OP_XOR:  id_out.alu_op = ALU_XOR;
               OP_SLT:  id_out.alu_op = ALU_SLT;
               OP_SLL:  id_out.alu_op = ALU_SLL;
               OP_SRL:  id_out.alu_op = ALU_SRL;
               default: id_out.alu_op = ALU_ADD;
            endcase
         end
         OP_ADDI: begin
            id_out.valid               = 1'b1;
            id_out.ctrl[CTL_REG_WRITE] = 1'b1;
            id_out.use_rs1             = 1'b1;
         end
         OP_LDW, OP_LDB: begin
            id_out.valid               = 1'b1;
            id_out.ctrl[CTL_MEM_READ]  = 1'b1;
            id_out.ctrl[CTL_REG_WRITE] = 1'b1;
            id_out.ctrl[CTL_LOAD]      = 1'b1;
            id_out.ctrl[CTL_BYTE_SEL]  = (opcode == OP_LDB);
            id_out.use_rs1             = 1'b1;
         end
         OP_STW, OP_STB: begin
            id_out.valid               = 1'b1;
            id_out.ctrl[CTL_MEM_WRITE] = 1'b1;
            id_out.ctrl[CTL_BYTE_SEL]  = (opcode == OP_STB);
            id_out.use_rs1             = 1'b1;
            id_out.use_rs2             = 1'b1;
         end
         // OP_NOP and anything unknown stay a bubble
         default: begin
            id_out.valid = 1'b0;
         end
      endcase
   end

endmodule

//--- src/forwarding_unit.sv
`timescale 1ns/10ps

module forwarding_unit (
   input  logic [proc_pkg::REG_IDX_W-1:0] ex_rs1,
   input  logic [proc_pkg::REG_IDX_W-1:0] ex_rs2,
   input  logic [proc_pkg::XLEN-1:0]      ex_rs1_data,
   input  logic [proc_pkg::XLEN-1:0]      ex_rs2_data,
   input  logic [proc_pkg::REG_IDX_W-1:0] m_rd,
   input  logic                           m_write,
   input  logic [proc_pkg::XLEN-1:0]      m_result,
   input  logic [proc_pkg::REG_IDX_W-1:0] wb_rd,
   input  logic                           wb_write,
   input  logic [proc_pkg::XLEN-1:0]      wb_data,
   output logic [proc_pkg::XLEN-1:0]      fw_s1,
   output logic [proc_pkg::XLEN-1:0]      fw_s2
);

   import proc_pkg::*;

   // Youngest producer first, r0 never forwards
   function automatic logic [XLEN-1:0] pick(input logic [REG_IDX_W-1:0] idx,
                                             input logic [XLEN-1:0]      reg_val);
      logic [XLEN-1:0] val;
      if (m_write && (m_rd != '0) && (m_rd == idx)) begin
         val = m_result;
      end else if (wb_write && (wb_rd != '0) && (wb_rd == idx)) begin
         val = wb_data;
      end else begin
         val = reg_val;
      end
      return val;
   endfunction

   always_comb begin
      fw_s1 = pick(ex_rs1, ex_rs1_data);
      fw_s2 = pick(ex_rs2, ex_rs2_data);
   end

endmodule

//--- src/hazard_unit.sv
`timescale 1ns/10ps

module hazard_unit (
   input  logic [proc_pkg::REG_IDX_W-1:0] id_rs1,
   input  logic [proc_pkg::REG_IDX_W-1:0] id_rs2,
   input  logic                           id_use_rs1,
   input  logic                           id_use_rs2,
   input  logic [proc_pkg::REG_IDX_W-1:0] ex_rd,
   input  logic                           ex_load,
   output logic                           stall
);

   import proc_pkg::*;

   logic hit_rs1;
   logic hit_rs2;

   // Only sources the decode instruction really reads
   assign hit_rs1 = id_use_rs1 && (id_rs1 == ex_rd);
   assign hit_rs2 = id_use_rs2 && (id_rs2 == ex_rd);

   // Load data is not ready until M/WB, so hold decode one cycle
   assign stall = ex_load && (ex_rd != REG_IDX_W'(0)) && (hit_rs1 || hit_rs2);

endmodule

//--- src/proc.sv
`timescale 1ns/10ps

module proc #(
   parameter int DMEM_WORDS = 64
) (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           ir_valid,
   input  logic [proc_pkg::XLEN-1:0]      ir,
   output logic                           stall,
   output logic                           wb_valid,
   output logic [proc_pkg::REG_IDX_W-1:0] wb_index,
   output logic [proc_pkg::XLEN-1:0]      wb_data
);

   import proc_pkg::*;

   if_id_t if_id_d, if_id_q;
   id_ex_t id_ex_d, id_ex_q;
   ex_m_t  ex_m_d, ex_m_q;
   m_wb_t  m_wb_d, m_wb_q;

   id_ex_t               id_out;
   logic [REG_IDX_W-1:0] ex_rs1_idx;
   logic [REG_IDX_W-1:0] ex_rs2_idx;
   logic [XLEN-1:0]      fw_s1;
   logic [XLEN-1:0]      fw_s2;
   logic [XLEN-1:0]      alu_b;
   logic [XLEN-1:0]      alu_result;
   logic [XLEN-1:0]      mem_rdata;
   logic                 m_write;
   logic                 wb_write;
   logic [XLEN-1:0]      wb_value;

   ////////////////////
   // IR and decode
   assign if_id_d.valid = ir_valid;
   assign if_id_d.instr = ir;

   // Held on a stall, bubble when nothing is offered
   stage_reg #(.payload_t(if_id_t)) if_id (
      .clk(clk), .rst_n(rst_n), .en(!stall), .bubble(!ir_valid && !stall),
      .d(if_id_d), .q(if_id_q)
   );

   decode u_decode (
      .clk(clk), .rst_n(rst_n), .ir(if_id_q.instr),
      .wb_write(wb_write), .wb_index(m_wb_q.rd), .wb_data(wb_value),
      .id_out(id_out)
   );

   hazard_unit u_hazard (
      .id_rs1(id_out.rs1), .id_rs2(id_out.rs2),
      .id_use_rs1(id_out.use_rs1), .id_use_rs2(id_out.use_rs2),
      .ex_rd(id_ex_q.rd), .ex_load(id_ex_q.valid && id_ex_q.ctrl[CTL_LOAD]),
      .stall(stall)
   );

   always_comb begin
      id_ex_d       = id_out;
      id_ex_d.valid = id_out.valid && if_id_q.valid;
   end

   stage_reg #(.payload_t(id_ex_t)) id_ex (
      .clk(clk), .rst_n(rst_n), .en(1'b1), .bubble(stall),
      .d(id_ex_d), .q(id_ex_q)
   );

   ////////////////////
   // Execute
   assign ex_rs1_idx = id_ex_q.use_rs1 ? id_ex_q.rs1 : '0;
   assign ex_rs2_idx = id_ex_q.use_rs2 ? id_ex_q.rs2 : '0;
   // Loads still sit in EX/M, the stall covers them
   assign m_write    = ex_m_q.valid && ex_m_q.ctrl[CTL_REG_WRITE] && !ex_m_q.ctrl[CTL_LOAD];

   forwarding_unit u_fwd (
      .ex_rs1(ex_rs1_idx), .ex_rs2(ex_rs2_idx),
      .ex_rs1_data(id_ex_q.rs1_data), .ex_rs2_data(id_ex_q.rs2_data),
      .m_rd(ex_m_q.rd), .m_write(m_write), .m_result(ex_m_q.result),
      .wb_rd(m_wb_q.rd), .wb_write(wb_write), .wb_data(wb_value),
      .fw_s1(fw_s1), .fw_s2(fw_s2)
   );

   // y_sel high picks the register operand
   assign alu_b = id_ex_q.y_sel ? fw_s2 : id_ex_q.imm;

   alu u_alu (
      .op(id_ex_q.alu_op), .a(fw_s1), .b(alu_b), .result(alu_result)
   );

   always_comb begin
      ex_m_d.valid      = id_ex_q.valid;
      ex_m_d.ctrl       = id_ex_q.ctrl;
      ex_m_d.result     = alu_result;
      ex_m_d.store_data = fw_s2;
      ex_m_d.rd         = id_ex_q.rd;
   end

   stage_reg #(.payload_t(ex_m_t)) ex_m (
      .clk(clk), .rst_n(rst_n), .en(1'b1), .bubble(1'b0),
      .d(ex_m_d), .q(ex_m_q)
   );

   ////////////////////
   // Memory
   data_mem #(.DMEM_WORDS(DMEM_WORDS)) u_dmem (
      .clk(clk),
      .read(ex_m_q.valid && ex_m_q.ctrl[CTL_MEM_READ]),
      .write(ex_m_q.valid && ex_m_q.ctrl[CTL_MEM_WRITE]),
      .byte_sel(ex_m_q.ctrl[CTL_BYTE_SEL]),
      .addr(ex_m_q.result), .wdata(ex_m_q.store_data), .rdata(mem_rdata)
   );

   always_comb begin
      m_wb_d.valid     = ex_m_q.valid;
      m_wb_d.ctrl      = ex_m_q.ctrl;
      m_wb_d.result    = ex_m_q.result;
      m_wb_d.load_data = mem_rdata;
      m_wb_d.rd        = ex_m_q.rd;
   end

   stage_reg #(.payload_t(m_wb_t)) m_wb (
      .clk(clk), .rst_n(rst_n), .en(1'b1), .bubble(1'b0),
      .d(m_wb_d), .q(m_wb_q)
   );

   ////////////////////
   // Writeback
   assign wb_write = m_wb_q.valid && m_wb_q.ctrl[CTL_REG_WRITE];
   assign wb_value = m_wb_q.ctrl[CTL_LOAD] ? m_wb_q.load_data : m_wb_q.result;

   // Strobe on the same edge as the register file write
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wb_valid <= 1'b0;
      end else begin
         wb_valid <= wb_write;
      end
   end

   always_ff @(posedge clk) begin
      wb_index <= m_wb_q.rd;
      wb_data  <= wb_value;
   end

endmodule

//--- src/proc_pkg.sv
package proc_pkg;

   localparam int XLEN      = 32;
   localparam int REG_IDX_W = 5;
   localparam int OPC_W     = 6;

   ////////////////////
   // Opcodes in ir[31:26]
   localparam logic [OPC_W-1:0] OP_NOP  = 6'd0;
   localparam logic [OPC_W-1:0] OP_ADD  = 6'd1;
   localparam logic [OPC_W-1:0] OP_SUB  = 6'd2;
   localparam logic [OPC_W-1:0] OP_AND  = 6'd3;
   localparam logic [OPC_W-1:0] OP_OR   = 6'd4;
   localparam logic [OPC_W-1:0] OP_XOR  = 6'd5;
   localparam logic [OPC_W-1:0] OP_SLT  = 6'd6;
   localparam logic [OPC_W-1:0] OP_SLL  = 6'd7;
   localparam logic [OPC_W-1:0] OP_SRL  = 6'd8;
   localparam logic [OPC_W-1:0] OP_ADDI = 6'd9;
   localparam logic [OPC_W-1:0] OP_LDW  = 6'd10;
   localparam logic [OPC_W-1:0] OP_LDB  = 6'd11;
   localparam logic [OPC_W-1:0] OP_STW  = 6'd12;
   localparam logic [OPC_W-1:0] OP_STB  = 6'd13;

   // Instruction field positions
   localparam int FLD_OPC_HI = 31;
   localparam int FLD_OPC_LO = 26;
   localparam int FLD_RD_HI  = 25;
   localparam int FLD_RD_LO  = 21;
   localparam int FLD_RS1_HI = 20;
   localparam int FLD_RS1_LO = 16;
   localparam int FLD_RS2_HI = 15;
   localparam int FLD_RS2_LO = 11;
   localparam int FLD_IMM_HI = 15;
   localparam int FLD_IMM_LO = 0;

   ////////////////////
   // Control word bit positions
   typedef logic [4:0] ctrl_t;
   localparam int CTL_MEM_READ  = 0;
   localparam int CTL_MEM_WRITE = 1;
   localparam int CTL_BYTE_SEL  = 2;
   localparam int CTL_REG_WRITE = 3;
   localparam int CTL_LOAD      = 4;

   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLT,
      ALU_SLL,
      ALU_SRL
   } alu_op_t;

   ////////////////////
   // Stage register payloads
   typedef struct packed {
      logic            valid;
      logic [XLEN-1:0] instr;
   } if_id_t;

   typedef struct packed {
      logic                 valid;
      ctrl_t                ctrl;
      alu_op_t              alu_op;
      logic [XLEN-1:0]      rs1_data;
      logic [XLEN-1:0]      rs2_data;
      logic [XLEN-1:0]      imm;
      logic                 y_sel;
      logic [REG_IDX_W-1:0] rs1;
      logic [REG_IDX_W-1:0] rs2;
      logic [REG_IDX_W-1:0] rd;
      logic                 use_rs1;
      logic                 use_rs2;
   } id_ex_t;

   typedef struct packed {
      logic                 valid;
      ctrl_t                ctrl;
      logic [XLEN-1:0]      result;
      logic [XLEN-1:0]      store_data;
      logic [REG_IDX_W-1:0] rd;
   } ex_m_t;

   typedef struct packed {
      logic                 valid;
      ctrl_t                ctrl;
      logic [XLEN-1:0]      result;
      logic [XLEN-1:0]      load_data;
      logic [REG_IDX_W-1:0] rd;
   } m_wb_t;

endpackage

//--- src/stage_reg.sv
`timescale 1ns/10ps

module stage_reg #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     en,
   input  logic     bubble,
   input  payload_t d,
   output payload_t q
);

   // An all-zero payload is a bubble: valid and ctrl both cleared
   always_ff @(posedge clk) begin
      if (!rst_n || bubble) begin
         q <= '0;
      end else if (en) begin
         q <= d;
      end
   end

endmodule

//--- verif/proc_tb.sv
`timescale 1ns/10ps

module proc_tb;

   import proc_pkg::*;

   localparam int          DMEM_WORDS = 64;
   localparam logic [31:0] SEED       = 32'hc161f5cd;

   logic                 clk;
   logic                 rst_n;
   logic                 ir_valid;
   logic [XLEN-1:0]      ir;
   logic                 stall;
   logic                 wb_valid;
   logic [REG_IDX_W-1:0] wb_index;
   logic [XLEN-1:0]      wb_data;

   // Stimulus table: word, issue with no idle gap, stall expected after it
   logic [XLEN-1:0] prog_word [$];
   logic            prog_tight [$];
   logic            prog_stall [$];

   // Expected writebacks in program order, head advanced by the monitor
   logic [REG_IDX_W-1:0] exp_idx [$];
   logic [XLEN-1:0]      exp_data [$];
   int                   exp_cyc [$];
   int                   head;

   // Reference machine state
   logic [XLEN-1:0] model_rf [32];
   logic [XLEN-1:0] model_mem [DMEM_WORDS];

   int   cycle;
   int   limit;
   int   wb_errs;
   int   stall_errs;
   int   checked;
   logic stall_exp;

   proc #(.DMEM_WORDS(DMEM_WORDS)) DUT (
      .clk(clk), .rst_n(rst_n), .ir_valid(ir_valid), .ir(ir),
      .stall(stall), .wb_valid(wb_valid), .wb_index(wb_index), .wb_data(wb_data)
   );

   ////////////////////
   // Instruction encoding
   function automatic logic [XLEN-1:0] reg_op(input logic [5:0] op, input int rd,
                                              input int rs1, input int rs2);
      return {op, 5'(rd), 5'(rs1), 5'(rs2), 11'd0};
   endfunction

   function automatic logic [XLEN-1:0] imm_op(input logic [5:0] op, input int rd,
                                              input int rs1, input logic [15:0] imm);
      return {op, 5'(rd), 5'(rs1), imm};
   endfunction

   task automatic add_entry(input logic [XLEN-1:0] word, input logic tight, input logic stl);
      prog_word.push_back(word);
      prog_tight.push_back(tight);
      prog_stall.push_back(stl);
   endtask

   task automatic build_table();
      // ALU and immediate operations, dependent chains
      add_entry(imm_op(OP_ADDI, 1, 0, 16'h1234), 1'b0, 1'b0);
      add_entry(imm_op(OP_ADDI, 2, 0, 16'hfffb), 1'b0, 1'b0);
      add_entry(reg_op(OP_ADD, 3, 1, 2), 1'b1, 1'b0);
      add_entry(reg_op(OP_SUB, 4, 1, 2), 1'b1, 1'b0);
      add_entry(reg_op(OP_AND, 5, 3, 4), 1'b1, 1'b0);
      add_entry(reg_op(OP_OR, 6, 3, 2), 1'b0, 1'b0);
      add_entry(reg_op(OP_XOR, 7, 6, 1), 1'b1, 1'b0);
      add_entry(reg_op(OP_SLT, 8, 2, 1), 1'b0, 1'b0);
      add_entry(reg_op(OP_SLT, 9, 1, 2), 1'b1, 1'b0);
      add_entry(imm_op(OP_ADDI, 10, 0, 16'h0004), 1'b0, 1'b0);
      add_entry(reg_op(OP_SLL, 11, 1, 10), 1'b1, 1'b0);
      add_entry({OP_NOP, 26'd0}, 1'b1, 1'b0);
      // r10 is read in decode while its writeback is in progress
      add_entry(reg_op(OP_SRL, 12, 2, 10), 1'b1, 1'b0);
      // r0 is written but must read back as zero
      add_entry(imm_op(OP_ADDI, 0, 1, 16'd77), 1'b0, 1'b0);
      add_entry(reg_op(OP_ADD, 13, 0, 1), 1'b1, 1'b0);
      // Word store then load
      add_entry(imm_op(OP_ADDI, 14, 0, 16'h0040), 1'b0, 1'b0);
      add_entry(imm_op(OP_STW, 7, 14, 16'h0000), 1'b1, 1'b0);
      add_entry(imm_op(OP_LDW, 15, 14, 16'h0000), 1'b1, 1'b0);
      add_entry(reg_op(OP_ADD, 16, 15, 1), 1'b1, 1'b1);
      // Byte lanes of word 0x44
      add_entry(imm_op(OP_STW, 2, 14, 16'h0004), 1'b0, 1'b0);
      add_entry(imm_op(OP_ADDI, 17, 0, 16'h0011), 1'b0, 1'b0);
      add_entry(imm_op(OP_STB, 17, 14, 16'h0005), 1'b1, 1'b0);
      add_entry(imm_op(OP_ADDI, 18, 0, 16'h0022), 1'b0, 1'b0);
      add_entry(imm_op(OP_STB, 18, 14, 16'h0006), 1'b1, 1'b0);
      add_entry(imm_op(OP_STB, 0, 14, 16'h0007), 1'b0, 1'b0);
      add_entry(imm_op(OP_STB, 1, 14, 16'h0004), 1'b0, 1'b0);
      add_entry(imm_op(OP_LDW, 19, 14, 16'h0004), 1'b1, 1'b0);
      add_entry(imm_op(OP_LDB, 20, 14, 16'h0004), 1'b0, 1'b0);
      add_entry(imm_op(OP_LDB, 21, 14, 16'h0005), 1'b1, 1'b0);
      add_entry(imm_op(OP_LDB, 22, 14, 16'h0006), 1'b1, 1'b0);
      add_entry(imm_op(OP_LDB, 23, 14, 16'h0007), 1'b1, 1'b0);
      // Load-use pairs on rs2, store data and rs1
      add_entry(imm_op(OP_LDB, 24, 14, 16'h0004), 1'b0, 1'b0);
      add_entry(reg_op(OP_SUB, 25, 1, 24), 1'b1, 1'b1);
      add_entry(imm_op(OP_LDW, 26, 14, 16'h0000), 1'b0, 1'b0);
      add_entry(imm_op(OP_STW, 26, 14, 16'h000c), 1'b1, 1'b1);
      add_entry(imm_op(OP_LDW, 27, 14, 16'h000c), 1'b1, 1'b0);
      add_entry(imm_op(OP_LDW, 28, 14, 16'h0000), 1'b0, 1'b0);
      add_entry(imm_op(OP_ADDI, 29, 28, 16'h0003), 1'b1, 1'b1);
      // No stall: imm bits alias r30 and a load into r0
      add_entry(imm_op(OP_LDW, 30, 14, 16'h0000), 1'b0, 1'b0);
      add_entry(imm_op(OP_ADDI, 31, 0, 16'hf000), 1'b1, 1'b0);
      add_entry(imm_op(OP_LDW, 0, 14, 16'h0000), 1'b0, 1'b0);
      add_entry(reg_op(OP_ADD, 5, 0, 0), 1'b1, 1'b0);
      add_entry({6'd63, 26'h3ffffff}, 1'b0, 1'b0);
      add_entry(reg_op(OP_SRL, 6, 2, 14), 1'b0, 1'b0);
   endtask

   ////////////////////
   // Reference model, one instruction in program order
   task automatic run_model(input logic [XLEN-1:0] w, input int wb_cyc);
      logic [5:0]           op;
      logic [REG_IDX_W-1:0] rd;
      logic [XLEN-1:0]      a;
      logic [XLEN-1:0]      b;
      logic [XLEN-1:0]      imm;
      logic [XLEN-1:0]      addr;
      logic [XLEN-1:0]      val;
      logic                 wr;
      int                   wi;
      int                   lane;
      op   = w[31:26];
      rd   = w[25:21];
      a    = model_rf[w[20:16]];
      b    = model_rf[w[15:11]];
      imm  = {{16{w[15]}}, w[15:0]};
      addr = a + imm;
      wi   = int'(addr[7:2]) % DMEM_WORDS;
      lane = int'(addr[1:0]);
      wr   = 1'b1;
      val  = '0;
      case (op)
         OP_ADD:  val = a + b;
         OP_SUB:  val = a - b;
         OP_AND:  val = a & b;
         OP_OR:   val = a | b;
         OP_XOR:  val = a ^ b;
         OP_SLT:  val = {31'd0, $signed(a) < $signed(b)};
         OP_SLL:  val = a << b[4:0];
         OP_SRL:  val = a >> b[4:0];
         OP_ADDI: val = a + imm;
         OP_LDW:  val = model_mem[wi];
         OP_LDB:  val = {24'd0, model_mem[wi][8 * lane +: 8]};
         OP_STW: begin
            model_mem[wi] = model_rf[rd];
            wr = 1'b0;
         end
         OP_STB: begin
            model_mem[wi][8 * lane +: 8] = model_rf[rd][7:0];
            wr = 1'b0;
         end
         default: wr = 1'b0;
      endcase
      if (wr) begin
         exp_idx.push_back(rd);
         exp_data.push_back(val);
         exp_cyc.push_back(wb_cyc);
         if (rd != '0) begin
            model_rf[rd] = val;
         end
      end
   endtask

   // One clock: drive after the edge, check stall and decide acceptance at negedge
   task automatic step_cycle(input logic v, input logic [XLEN-1:0] w, output logic acc);
      @(posedge clk);
      #5;
      ir_valid = v;
      ir       = w;
      @(negedge clk);
      if (stall !== stall_exp) begin
         stall_errs++;
         $display("MISMATCH at %0t: stall expected %b got %b", $time, stall_exp, stall);
      end
      acc = v && (stall === 1'b0);
   endtask

   ////////////////////
   // Clock and cycle limit
   initial begin
      clk = 1'b0;
      forever begin
         #50 clk = ~clk;
      end
   end

   always @(posedge clk) begin
      cycle <= cycle + 1;
      if (cycle >= limit) begin
         $display("Run stopped at cycle %0d before all writebacks arrived", cycle);
         $display("Writeback errors: %0d, stall errors: %0d, strobes checked: %0d",
                  wb_errs, stall_errs, checked);
         $display("Verification failed");
         $finish;
      end
   end

   ////////////////////
   // Writeback monitor
   task automatic compare_strobe();
      if (exp_cyc[head] != cycle) begin
         wb_errs++;
         $display("MISMATCH at %0t: wb_valid cycle expected %0d got %0d",
                  $time, exp_cyc[head], cycle);
      end
      if (wb_index !== exp_idx[head]) begin
         wb_errs++;
         $display("MISMATCH at %0t: wb_index expected %0d got %0d",
                  $time, exp_idx[head], wb_index);
      end
      if (wb_data !== exp_data[head]) begin
         wb_errs++;
         $display("MISMATCH at %0t: wb_data expected %h got %h", $time, exp_data[head], wb_data);
      end
      checked++;
      head++;
   endtask

   initial begin
      head    = 0;
      wb_errs = 0;
      checked = 0;
   end

   always @(negedge clk) begin
      if (rst_n === 1'b1) begin
         if (wb_valid === 1'b1) begin
            if (head >= exp_cyc.size()) begin
               wb_errs++;
               $display("Extra writeback strobe at %0t for r%0d", $time, wb_index);
            end else begin
               compare_strobe();
            end
         end else if (wb_valid !== 1'b0) begin
            wb_errs++;
            $display("MISMATCH at %0t: wb_valid expected 0 got %b", $time, wb_valid);
         end else if ((head < exp_cyc.size()) && (exp_cyc[head] <= cycle)) begin
            wb_errs++;
            $display("No writeback strobe at %0t for r%0d", $time, exp_idx[head]);
            head++;
         end
      end
   end

   ////////////////////
   // Stimulus
   initial begin
      int   i;
      int   gap;
      logic acc;
      rst_n      = 1'b0;
      ir_valid   = 1'b0;
      ir         = '0;
      stall_exp  = 1'b0;
      stall_errs = 0;
      void'($urandom(SEED));
      for (i = 0; i < 32; i++) begin
         model_rf[i] = '0;
      end
      build_table();
      limit = 16 + 3 * prog_word.size() + 20;

      repeat (16) @(posedge clk);
      #5;
      rst_n = 1'b1;

      for (i = 0; i < prog_word.size(); i++) begin
         if (!prog_tight[i]) begin
            gap = 1 + int'($urandom % 2);
            repeat (gap) begin
               step_cycle(1'b0, '0, acc);
               stall_exp = 1'b0;
            end
         end
         acc = 1'b0;
         // Hold the word while the core stalls
         while (!acc) begin
            step_cycle(1'b1, prog_word[i], acc);
            if (acc) begin
               run_model(prog_word[i], cycle + 5 + int'(prog_stall[i]));
               stall_exp = prog_stall[i];
            end else begin
               stall_exp = 1'b0;
            end
         end
      end

      // Drain, then a few idle cycles to catch stray strobes
      while (head < exp_cyc.size()) begin
         step_cycle(1'b0, '0, acc);
         stall_exp = 1'b0;
      end
      repeat (4) begin
         step_cycle(1'b0, '0, acc);
         stall_exp = 1'b0;
      end
      if (checked != exp_cyc.size()) begin
         wb_errs++;
         $display("Only %0d of %0d expected writebacks arrived", checked, exp_cyc.size());
      end

      $display("Writeback errors: %0d, stall errors: %0d, strobes checked: %0d",
               wb_errs, stall_errs, checked);
      if ((wb_errs == 0) && (stall_errs == 0)) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule
